//--- Makefile
TOP := lsu_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it, log in sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): tb.f $(wildcard logic/*.sv logic/*.svh tests/*.sv)
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o V$(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Errors found" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- logic/axil_data_ram.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsu_defines.svh"

module axil_data_ram (
    input  logic               clock,
    input  logic               reset,

    input  logic               aw_valid,
    input  lsu_pkg::axil_aw_t  aw,
    output logic               aw_ready,

    input  logic               w_valid,
    input  lsu_pkg::axil_w_t   w,
    output logic               w_ready,

    output logic               b_valid,
    output lsu_pkg::axil_b_t   b,
    input  logic               b_ready,

    input  logic               ar_valid,
    input  lsu_pkg::axil_ar_t  ar,
    output logic               ar_ready,

    output logic               r_valid,
    output lsu_pkg::axil_r_t   r,
    input  logic               r_ready
);

    import lsu_pkg::*;

    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    logic [`LSU_DATA_W-1:0] mem [`LSU_MEM_WORDS];

    logic                   have_aw;
    logic                   have_w;
    axil_aw_t               aw_q;
    axil_w_t                w_q;
    axil_aw_t               wr_aw;
    axil_w_t                wr_w;
    logic                   busy;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   ar_hs;
    logic                   wr_fire;
    logic [IDX_W-1:0]       wr_idx;
    logic [IDX_W-1:0]       rd_idx;
    logic [`LSU_DATA_W-1:0] r_data_q;

    assign busy     = b_valid | r_valid;  // response still pending
    assign aw_ready = ~have_aw & ~busy;
    assign w_ready  = ~have_w & ~busy;
    // a started write goes first
    assign ar_ready = ~have_aw & ~have_w & ~aw_valid & ~w_valid & ~busy;

    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign ar_hs = ar_valid & ar_ready;

    assign wr_aw   = have_aw ? aw_q : aw;
    assign wr_w    = have_w ? w_q : w;
    assign wr_fire = (have_aw | aw_hs) & (have_w | w_hs);

    assign wr_idx = wr_aw.addr[IDX_W+1:2];
    assign rd_idx = ar.addr[IDX_W+1:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            have_aw <= 1'b0;
            have_w  <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_fire) begin
                have_aw <= 1'b0;
                have_w  <= 1'b0;
                b_valid <= 1'b1;
            end else begin
                if (aw_hs) begin
                    have_aw <= 1'b1;
                end
                if (w_hs) begin
                    have_w <= 1'b1;
                end
                if (b_valid && b_ready) begin
                    b_valid <= 1'b0;
                end
            end
            if (ar_hs) begin
                r_valid <= 1'b1;
            end else if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            aw_q <= aw;
        end
        if (w_hs) begin
            w_q <= w;
        end
        if (wr_fire) begin
            for (int i = 0; i < `LSU_STRB_W; i++) begin
                if (wr_w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_w.data[8*i +: 8];
                end
            end
        end
        if (ar_hs) begin
            r_data_q <= mem[rd_idx];  // registered read
        end
    end

    assign b = '{resp: AXIL_RESP_OKAY};
    assign r = '{data: r_data_q, resp: AXIL_RESP_OKAY};

endmodule

`default_nettype wire

//--- logic/lsu.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu (
    input  logic               clock,
    input  logic               reset,

    input  logic               exu_valid,
    input  lsu_pkg::exu_lsu_t  exu,
    output logic               exu_ready,

    output logic               wbu_valid,
    output lsu_pkg::lsu_wbu_t  wbu,
    input  logic               wbu_ready,

    output logic               aw_valid,
    output lsu_pkg::axil_aw_t  aw,
    input  logic               aw_ready,

    output logic               w_valid,
    output lsu_pkg::axil_w_t   w,
    input  logic               w_ready,

    input  logic               b_valid,
    input  lsu_pkg::axil_b_t   b,
    output logic               b_ready,

    output logic               ar_valid,
    output lsu_pkg::axil_ar_t  ar,
    input  logic               ar_ready,

    input  logic               r_valid,
    input  lsu_pkg::axil_r_t   r,
    output logic               r_ready
);

    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } lsu_state_e;

    lsu_state_e             state;
    lsu_state_e             state_next;
    exu_lsu_t               op_q;
    logic [`LSU_DATA_W-1:0] result_q;
    logic [`LSU_DATA_W-1:0] wdata;
    logic [`LSU_STRB_W-1:0] wstrb;
    logic [`LSU_DATA_W-1:0] load_value;
    logic                   accept;
    logic                   r_hs;
    logic                   b_hs;

    assign exu_ready = (state == IDLE);
    assign accept    = exu_valid & exu_ready;
    assign wbu_valid = (state == RESPOND);

    // only the response of the issued access is taken
    assign r_ready = (state == ACCESS) & (op_q.op == OP_LOAD);
    assign b_ready = (state == ACCESS) & (op_q.op == OP_STORE);
    assign r_hs    = r_valid & r_ready;
    assign b_hs    = b_valid & b_ready;  // b.resp ignored, errors not trapped

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    case (exu.op)
                        OP_LOAD, OP_STORE: state_next = ACCESS;
                        default:           state_next = RESPOND;  // pass-through
                    endcase
                end
            end
            ACCESS: begin
                if (r_hs || b_hs) begin
                    state_next = RESPOND;
                end
            end
            RESPOND: begin
                if (wbu_ready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= IDLE;
            ar_valid <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                ar_valid <= (exu.op == OP_LOAD);
                aw_valid <= (exu.op == OP_STORE);
                w_valid  <= (exu.op == OP_STORE);
            end else begin
                if (ar_ready) begin
                    ar_valid <= 1'b0;
                end
                if (aw_ready) begin
                    aw_valid <= 1'b0;
                end
                if (w_ready) begin
                    w_valid <= 1'b0;
                end
            end
        end
    end

    // operation and result registers
    always_ff @(posedge clock) begin
        if (accept) begin
            op_q     <= exu;
            result_q <= exu.alu_res;  // kept as is for a pass-through
        end else if (r_hs) begin
            result_q <= load_value;
        end else if (b_hs) begin
            result_q <= '0;
        end
    end

    lsu_lane_align u_lane_align (
        .width      (op_q.width),
        .addr_low   (op_q.alu_res[1:0]),
        .sdata      (op_q.sdata),
        .rdata      (r.data),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .load_value (load_value)
    );

    assign aw = '{addr: op_q.alu_res};
    assign ar = '{addr: op_q.alu_res};
    assign w  = '{data: wdata, strb: wstrb};

    always_comb begin
        wbu.result    = result_q;
        wbu.dnpc      = op_q.dnpc;
        wbu.rd_addr   = op_q.rd_addr;
        wbu.wb        = op_q.wb;
        wbu.csr_addr  = op_q.csr_addr;
        wbu.csr_we    = op_q.csr_we;
        wbu.csr_wdata = op_q.csr_wdata;
    end

endmodule

`default_nettype wire

//--- logic/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// byte address width
`define LSU_ADDR_W    32

`define LSU_DATA_W    32

// one strobe bit per data byte
`define LSU_STRB_W    (`LSU_DATA_W / 8)

// data memory depth in words, wraps on the low address bits
`define LSU_MEM_WORDS 256

`endif

//--- logic/lsu_lane_align.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_lane_align (
    input  lsu_pkg::mem_width_e     width,
    input  logic [1:0]              addr_low,
    input  logic [`LSU_DATA_W-1:0]  sdata,
    input  logic [`LSU_DATA_W-1:0]  rdata,
    output logic [`LSU_DATA_W-1:0]  wdata,
    output logic [`LSU_STRB_W-1:0]  wstrb,
    output logic [`LSU_DATA_W-1:0]  load_value
);

    import lsu_pkg::*;

    logic [`LSU_STRB_W-1:0] strb_base;
    logic [`LSU_DATA_W-1:0] rshift;

    assign wdata = sdata << {addr_low, 3'b000};  // byte lane placement

    always_comb begin
        case (width)
            MW_BYTE: strb_base = 4'b0001;
            MW_HALF: strb_base = 4'b0011;
            MW_WORD: strb_base = 4'b1111;
            default: strb_base = 4'b0000;  // not a store width
        endcase
    end

    assign wstrb = strb_base << addr_low;

    assign rshift = rdata >> {addr_low, 3'b000};  // addressed byte to lane 0

    always_comb begin
        case (width)
            MW_BYTE: begin
                load_value = {{24{rshift[7]}}, rshift[7:0]};
            end
            MW_HALF: begin
                load_value = {{16{rshift[15]}}, rshift[15:0]};
            end
            MW_WORD: begin
                load_value = rshift;
            end
            MW_BYTE_U: begin
                load_value = {24'b0, rshift[7:0]};
            end
            MW_HALF_U: begin
                load_value = {16'b0, rshift[15:0]};
            end
            default: begin
                load_value = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/lsu_pkg.sv
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,  // pass-through
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } lsu_op_e;

    // funct3 access codes
    typedef enum logic [2:0] {
        MW_BYTE   = 3'b000,
        MW_HALF   = 3'b001,
        MW_WORD   = 3'b010,
        MW_BYTE_U = 3'b100,
        MW_HALF_U = 3'b101
    } mem_width_e;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    typedef struct packed {
        lsu_op_e                op;
        mem_width_e             width;
        logic [`LSU_DATA_W-1:0] alu_res;    // address or bypass value
        logic [`LSU_DATA_W-1:0] sdata;
        logic [`LSU_ADDR_W-1:0] dnpc;
        logic [4:0]             rd_addr;
        logic                   wb;
        logic [11:0]            csr_addr;
        logic                   csr_we;
        logic [`LSU_DATA_W-1:0] csr_wdata;
    } exu_lsu_t;

    typedef struct packed {
        logic [`LSU_DATA_W-1:0] result;
        logic [`LSU_ADDR_W-1:0] dnpc;
        logic [4:0]             rd_addr;
        logic                   wb;
        logic [11:0]            csr_addr;
        logic                   csr_we;
        logic [`LSU_DATA_W-1:0] csr_wdata;
    } lsu_wbu_t;

    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [`LSU_DATA_W-1:0] data;
        logic [`LSU_STRB_W-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [`LSU_DATA_W-1:0] data;
        logic [1:0]             resp;
    } axil_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

endpackage

`default_nettype wire

//--- logic/lsu_top.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_top (
    input  logic               clock,
    input  logic               reset,
    input  logic               exu_valid,
    input  lsu_pkg::exu_lsu_t  exu,
    output logic               exu_ready,
    output logic               wbu_valid,
    output lsu_pkg::lsu_wbu_t  wbu,
    input  logic               wbu_ready
);

    import lsu_pkg::*;

    // AXI4-Lite between stage and memory
    logic     aw_valid;
    logic     aw_ready;
    axil_aw_t aw;
    logic     w_valid;
    logic     w_ready;
    axil_w_t  w;
    logic     b_valid;
    logic     b_ready;
    axil_b_t  b;
    logic     ar_valid;
    logic     ar_ready;
    axil_ar_t ar;
    logic     r_valid;
    logic     r_ready;
    axil_r_t  r;

    lsu u_lsu (
        .clock     (clock),
        .reset     (reset),
        .exu_valid (exu_valid),
        .exu       (exu),
        .exu_ready (exu_ready),
        .wbu_valid (wbu_valid),
        .wbu       (wbu),
        .wbu_ready (wbu_ready),
        .aw_valid  (aw_valid),
        .aw        (aw),
        .aw_ready  (aw_ready),
        .w_valid   (w_valid),
        .w         (w),
        .w_ready   (w_ready),
        .b_valid   (b_valid),
        .b         (b),
        .b_ready   (b_ready),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready)
    );

    axil_data_ram u_ram (
        .clock    (clock),
        .reset    (reset),
        .aw_valid (aw_valid),
        .aw       (aw),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w        (w),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b        (b),
        .b_ready  (b_ready),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r),
        .r_ready  (r_ready)
    );

endmodule

`default_nettype wire

//--- tb.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_lane_align.sv
logic/lsu.sv
logic/axil_data_ram.sv
logic/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

//--- tests/lsu_checker.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_checker (
    input logic              clock,
    input logic              reset,
    input logic              exu_valid,
    input logic              exu_ready,
    input logic              wbu_valid,
    input lsu_pkg::lsu_wbu_t wbu,
    input logic              wbu_ready
);

    int error_count = 0;  // read by the testbench

    a_wbu_hold: assert property (@(posedge clock) disable iff (reset)
        wbu_valid && !wbu_ready |=> wbu_valid && $stable(wbu))
    else begin
        $error("wbu_valid or wbu changed while wbu_ready was low");
        error_count = error_count + 1;
    end

    a_busy_while_wb: assert property (@(posedge clock) disable iff (reset)
        wbu_valid |-> !exu_ready)
    else begin
        $error("exu_ready high while a writeback is pending");
        error_count = error_count + 1;
    end

    // one operation in flight
    a_one_outstanding: assert property (@(posedge clock) disable iff (reset)
        exu_valid && exu_ready |=> !exu_ready)
    else begin
        $error("exu_ready still high after an accepted operation");
        error_count = error_count + 1;
    end

    a_ready_after_wb: assert property (@(posedge clock) disable iff (reset)
        wbu_valid && wbu_ready |=> exu_ready && !wbu_valid)
    else begin
        $error("stage not idle after the writeback transfer");
        error_count = error_count + 1;
    end

    a_reset_state: assert property (@(posedge clock)
        $past(reset) |-> !wbu_valid && exu_ready)
    else begin
        $error("wrong wbu_valid or exu_ready after reset");
        error_count = error_count + 1;
    end

endmodule

bind lsu_top lsu_checker u_checker (
    .clock     (clock),
    .reset     (reset),
    .exu_valid (exu_valid),
    .exu_ready (exu_ready),
    .wbu_valid (wbu_valid),
    .wbu       (wbu),
    .wbu_ready (wbu_ready)
);

`default_nettype wire

//--- tests/lsu_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_tb;

    import lsu_pkg::*;

    localparam int N_OPS          = 180;
    localparam int TIMEOUT_CYCLES = 40 * N_OPS;
    localparam int SHADOW_BYTES   = 4 * `LSU_MEM_WORDS;
    localparam int SHADOW_AW      = $clog2(SHADOW_BYTES);

    logic        clock = 1'b0;
    logic        reset;
    logic        exu_valid;
    exu_lsu_t    exu;
    logic        exu_ready;
    logic        wbu_valid;
    lsu_wbu_t    wbu;
    logic        wbu_ready;

    logic [7:0]  shadow [SHADOW_BYTES];  // byte image of the data memory
    lsu_wbu_t    expected_q [$];
    lsu_wbu_t    exp_wb;
    integer      seed       = 13703;
    integer      stall_seed = 13703;
    logic [31:0] rnd;
    logic [31:0] stall_rnd;
    logic        stall_en;
    logic [2:0]  hold_cnt;
    int          cycle_count;

    lsu_top DUT (
        .clock     (clock),
        .reset     (reset),
        .exu_valid (exu_valid),
        .exu       (exu),
        .exu_ready (exu_ready),
        .wbu_valid (wbu_valid),
        .wbu       (wbu),
        .wbu_ready (wbu_ready)
    );

    always #10 clock = ~clock;

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, want);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic fail_reason(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic void write_byte(input logic [31:0] addr, input logic [7:0] data);
        shadow[addr[SHADOW_AW-1:0]] = data;  // memory wraps on low bits
    endfunction

    function automatic logic [7:0] byte_at(input logic [31:0] addr);
        return shadow[addr[SHADOW_AW-1:0]];
    endfunction

    function automatic mem_width_e pick_width(input logic [31:0] r, input logic is_load);
        case (is_load ? r % 32'd5 : r % 32'd3)
            32'd0:   return MW_BYTE;
            32'd1:   return MW_HALF;
            32'd2:   return MW_WORD;
            32'd3:   return MW_BYTE_U;
            default: return MW_HALF_U;
        endcase
    endfunction

    // random fields around an address in a 16-word window
    function automatic exu_lsu_t make_op(input lsu_op_e kind, input mem_width_e width,
                                         input logic [3:0] word, input logic [1:0] offset);
        exu_lsu_t    op;
        logic [31:0] r;
        logic [1:0]  off;
        case (width)
            MW_HALF, MW_HALF_U: off = {offset[1], 1'b0};
            MW_WORD:            off = 2'b00;
            default:            off = offset;
        endcase
        op         = '0;
        op.op      = kind;
        op.width   = width;
        r          = $random(seed);
        op.alu_res = {r[31:10], 4'b0000, word, off};
        if (kind == OP_NONE) begin
            op.alu_res = $random(seed);
        end
        op.sdata     = $random(seed);
        op.dnpc      = $random(seed);
        r            = $random(seed);
        op.rd_addr   = r[4:0];
        op.wb        = r[5];
        op.csr_addr  = r[17:6];
        op.csr_we    = r[18];
        op.csr_wdata = $random(seed);
        return op;
    endfunction

    // stores also update the shadow memory
    task automatic predict(input exu_lsu_t op, output lsu_wbu_t e);
        logic [31:0] a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] word;
        a    = op.alu_res;
        b    = byte_at(a);
        h    = {byte_at(a + 32'd1), byte_at(a)};
        word = {byte_at(a + 32'd3), byte_at(a + 32'd2), h};
        e    = '0;
        if (op.op == OP_STORE) begin
            write_byte(a, op.sdata[7:0]);
            if (op.width != MW_BYTE) begin
                write_byte(a + 32'd1, op.sdata[15:8]);
            end
            if (op.width == MW_WORD) begin
                write_byte(a + 32'd2, op.sdata[23:16]);
                write_byte(a + 32'd3, op.sdata[31:24]);
            end
        end else if (op.op == OP_LOAD) begin
            case (op.width)
                MW_BYTE:   e.result = {{24{b[7]}}, b};
                MW_HALF:   e.result = {{16{h[15]}}, h};
                MW_BYTE_U: e.result = {24'h0, b};
                MW_HALF_U: e.result = {16'h0, h};
                default:   e.result = word;
            endcase
        end else begin
            e.result = op.alu_res;
        end
        e.dnpc      = op.dnpc;
        e.rd_addr   = op.rd_addr;
        e.wb        = op.wb;
        e.csr_addr  = op.csr_addr;
        e.csr_we    = op.csr_we;
        e.csr_wdata = op.csr_wdata;
    endtask

    // runs from falling edge to falling edge
    task automatic issue(input exu_lsu_t op);
        lsu_wbu_t e;
        predict(op, e);
        expected_q.push_back(e);
        exu       = op;
        exu_valid = 1'b1;
        while (!exu_ready) begin
            @(negedge clock);
        end
        @(negedge clock);
        exu_valid = 1'b0;
        if (op.op == OP_NONE) begin
            assert (wbu_valid)
                else fail_reason("pass-through result not valid one cycle after acceptance");
        end
    endtask

    initial begin
        reset     = 1'b1;
        exu_valid = 1'b0;
        exu       = '0;
        stall_en  = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < 16; i++) begin  // fills the whole window
            issue(make_op(OP_STORE, MW_WORD, 4'(i), 2'd0));
            issue(make_op(OP_LOAD, MW_WORD, 4'(i), 2'd0));
        end
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            issue(make_op(OP_STORE, rnd[4] ? MW_BYTE : MW_HALF, rnd[3:0], rnd[6:5]));
            issue(make_op(OP_LOAD, MW_WORD, rnd[3:0], 2'd0));
        end
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            issue(make_op(OP_LOAD, pick_width(rnd >> 8, 1'b1), rnd[19:16], rnd[21:20]));
        end
        stall_en = 1'b1;
        for (int i = 0; i < 60; i++) begin
            rnd = $random(seed);
            case (rnd % 32'd3)
                32'd0:   issue(make_op(OP_NONE, MW_WORD, 4'd0, 2'd0));
                32'd1:   issue(make_op(OP_LOAD, pick_width(rnd >> 8, 1'b1),
                                       rnd[19:16], rnd[21:20]));
                default: issue(make_op(OP_STORE, pick_width(rnd >> 8, 1'b0),
                                       rnd[19:16], rnd[21:20]));
            endcase
        end
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
        if (DUT.u_checker.error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("%0d checker assertion failures", DUT.u_checker.error_count);
            $display("Errors found");
            $fatal(1);
        end
    end

    // random wbu_ready stalls once enabled
    initial begin
        wbu_ready = 1'b0;
        hold_cnt  = 3'd0;
        forever begin
            @(negedge clock);
            if (hold_cnt == 3'd0) begin
                stall_rnd = $random(stall_seed);
                wbu_ready = !stall_en || stall_rnd[0];
                hold_cnt  = stall_rnd[3:1];
            end else begin
                hold_cnt = hold_cnt - 3'd1;
            end
            assert (DUT.u_checker.error_count == 0)
                else fail_reason("a handshake assertion in the checker failed");
            if (wbu_valid && wbu_ready) begin
                assert (expected_q.size() > 0)
                    else fail_reason("writeback transfer with no operation outstanding");
                exp_wb = expected_q.pop_front();
                assert (wbu.result == exp_wb.result)
                    else fail_value("wbu.result", wbu.result, exp_wb.result);
                assert (wbu.dnpc == exp_wb.dnpc)
                    else fail_value("wbu.dnpc", wbu.dnpc, exp_wb.dnpc);
                assert (wbu.rd_addr == exp_wb.rd_addr)
                    else fail_value("wbu.rd_addr", 32'(wbu.rd_addr), 32'(exp_wb.rd_addr));
                assert (wbu.wb == exp_wb.wb)
                    else fail_value("wbu.wb", 32'(wbu.wb), 32'(exp_wb.wb));
                assert (wbu.csr_addr == exp_wb.csr_addr)
                    else fail_value("wbu.csr_addr", 32'(wbu.csr_addr), 32'(exp_wb.csr_addr));
                assert (wbu.csr_we == exp_wb.csr_we)
                    else fail_value("wbu.csr_we", 32'(wbu.csr_we), 32'(exp_wb.csr_we));
                assert (wbu.csr_wdata == exp_wb.csr_wdata)
                    else fail_value("wbu.csr_wdata", wbu.csr_wdata, exp_wb.csr_wdata);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count = cycle_count + 1;
        end
        $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

endmodule

`default_nettype wire
